/* rvf_pkg.sv */
package rvf_pkg;

	// --------------------------------------------------
	// Widths and fixed values
	// --------------------------------------------------
	localparam int XLEN = 64;
	localparam int ILEN = 32;

	localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;
	localparam logic [ILEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0,x0,0.

	localparam int ROM_WORDS = 16;
	localparam int ROM_AW = 4; // Index comes from pc[5:2].

	// --------------------------------------------------
	// Instruction classes seen by the hazard logic
	// --------------------------------------------------
	typedef enum logic [2:0] {
		CLS_ALU    = 3'd0,
		CLS_LOAD   = 3'd1,
		CLS_STORE  = 3'd2,
		CLS_BRANCH = 3'd3,
		CLS_JUMP   = 3'd4,
		CLS_MULDIV = 3'd5,
		CLS_OTHER  = 3'd6
	} instr_class_e;

	// Major RV64 opcodes, bits [6:0] of the instruction.
	typedef enum logic [6:0] {
		LOAD     = 7'b000_0011,
		STORE    = 7'b010_0011,
		OP_IMM   = 7'b001_0011,
		OP_IMM32 = 7'b001_1011,
		OP       = 7'b011_0011,
		OP32     = 7'b011_1011,
		BRANCH   = 7'b110_0011,
		JAL      = 7'b110_1111,
		JALR     = 7'b110_0111,
		LUI      = 7'b011_0111,
		AUIPC    = 7'b001_0111
	} opcode_e;

	// --------------------------------------------------
	// IF/ID register command
	// --------------------------------------------------
	typedef enum logic [1:0] {
		ACT_ADVANCE = 2'd0,
		ACT_HOLD    = 2'd1,
		ACT_FLUSH   = 2'd2
	} fetch_action_e;

endpackage

/* pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     pc_hold_i,
	input  logic                     redirect_i,
	input  logic [rvf_pkg::XLEN-1:0] redirect_pc_i,
	output logic [rvf_pkg::XLEN-1:0] pc_o
);

	logic [rvf_pkg::XLEN-1:0] pc_q;
	logic [rvf_pkg::XLEN-1:0] pc_d;
	logic [rvf_pkg::XLEN-1:0] pc_seq;

	assign pc_seq = pc_q + 'd4; // Next word in program order.

	// --------------------------------------------------
	// Next PC selection
	// --------------------------------------------------
	always_comb begin
		if (redirect_i) begin
			pc_d = redirect_pc_i; // Redirect wins over a hold.
		end else if (pc_hold_i) begin
			pc_d = pc_q;
		end else begin
			pc_d = pc_seq;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= rvf_pkg::RESET_PC;
		end else begin
			pc_q <= pc_d;
		end
	end

	assign pc_o = pc_q;

endmodule

/* instr_rom.sv */
`timescale 1ns/1ps

module instr_rom (
	input  logic [rvf_pkg::XLEN-1:0] pc_i,
	output logic [rvf_pkg::ILEN-1:0] instr_o
);

	logic [rvf_pkg::ILEN-1:0] rom [rvf_pkg::ROM_WORDS];
	logic [rvf_pkg::ROM_AW-1:0] word_idx;

	initial begin
		$readmemh("program.hex", rom);
	end

	// Byte address to word index; the image repeats every 64 bytes.
	assign word_idx = pc_i[rvf_pkg::ROM_AW+1:2];

	assign instr_o = rom[word_idx];

endmodule

/* if_id_regs.sv */
`timescale 1ns/1ps

module if_id_regs (
	input  logic                     clk,
	input  logic                     rst_n,
	input  rvf_pkg::fetch_action_e   action_i,
	input  logic [rvf_pkg::XLEN-1:0] pc_if_id_i,
	input  logic [rvf_pkg::ILEN-1:0] instr_if_id_i,
	output logic [rvf_pkg::XLEN-1:0] pc_if_id_o,
	output logic [rvf_pkg::ILEN-1:0] instr_if_id_o,
	output logic                     valid_if_id_o
);

	logic [rvf_pkg::XLEN-1:0] pc_q;
	logic [rvf_pkg::ILEN-1:0] instr_q;
	logic                     valid_q;

	// --------------------------------------------------
	// Pipeline register update
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q    <= rvf_pkg::RESET_PC;
			instr_q <= rvf_pkg::NOP_INSTR; // ID starts out as a bubble.
			valid_q <= 1'b0;
		end else begin
			case (action_i)
				rvf_pkg::ACT_ADVANCE: begin
					pc_q    <= pc_if_id_i;
					instr_q <= instr_if_id_i;
					valid_q <= 1'b1;
				end
				rvf_pkg::ACT_FLUSH: begin
					pc_q    <= pc_if_id_i;
					instr_q <= rvf_pkg::NOP_INSTR; // Wrong-path fetch is dropped.
					valid_q <= 1'b0;
				end
				rvf_pkg::ACT_HOLD: begin
					pc_q    <= pc_q;
					instr_q <= instr_q;
					valid_q <= valid_q;
				end
				default: begin
					pc_q    <= pc_q; // Unused encoding behaves as a hold.
					instr_q <= instr_q;
					valid_q <= valid_q;
				end
			endcase
		end
	end

	assign pc_if_id_o    = pc_q;
	assign instr_if_id_o = instr_q;
	assign valid_if_id_o = valid_q;

endmodule

/* fetch_hazard_ctrl.sv */
`timescale 1ns/1ps

module fetch_hazard_ctrl (
	input  logic                   id_valid_i,
	input  rvf_pkg::instr_class_e  id_class_i,
	input  logic [4:0]             id_rs1_i,
	input  logic [4:0]             id_rs2_i,
	input  logic                   id_uses_rs1_i,
	input  logic                   id_uses_rs2_i,
	input  logic                   muldiv_done_i,
	input  logic                   ex_load_valid_i,
	input  logic [4:0]             ex_load_rd_i,
	input  logic                   redirect_i,
	output rvf_pkg::fetch_action_e action_o,
	output logic                   pc_hold_o
);

	logic muldiv_wait;
	logic rs1_match;
	logic rs2_match;
	logic load_use;

	// --------------------------------------------------
	// Hazard detection
	// --------------------------------------------------
	assign muldiv_wait = id_valid_i && (id_class_i == rvf_pkg::CLS_MULDIV) && !muldiv_done_i;

	assign rs1_match = id_uses_rs1_i && (id_rs1_i == ex_load_rd_i);
	assign rs2_match = id_uses_rs2_i && (id_rs2_i == ex_load_rd_i);

	// A load into x0 never creates a dependency.
	assign load_use = ex_load_valid_i && (ex_load_rd_i != 5'd0) && (rs1_match || rs2_match);

	// --------------------------------------------------
	// Action priority
	// --------------------------------------------------
	always_comb begin
		if (muldiv_wait) begin
			action_o = rvf_pkg::ACT_HOLD;
		end else if (load_use) begin
			action_o = rvf_pkg::ACT_HOLD;
		end else if (redirect_i) begin
			action_o = rvf_pkg::ACT_FLUSH;
		end else begin
			action_o = rvf_pkg::ACT_ADVANCE;
		end
	end

	// The held ID entry is older than the redirect, so the PC still moves.
	assign pc_hold_o = (action_o == rvf_pkg::ACT_HOLD) && !redirect_i;

endmodule

/* id_classify.sv */
`timescale 1ns/1ps

module id_classify (
	input  logic [rvf_pkg::ILEN-1:0] instr_i,
	output rvf_pkg::instr_class_e    class_o,
	output logic [4:0]               rd_o,
	output logic [4:0]               rs1_o,
	output logic [4:0]               rs2_o,
	output logic                     uses_rs1_o,
	output logic                     uses_rs2_o
);

	rvf_pkg::opcode_e opcode;
	logic [6:0]       funct7;

	assign opcode = rvf_pkg::opcode_e'(instr_i[6:0]);
	assign funct7 = instr_i[31:25];

	assign rd_o  = instr_i[11:7];
	assign rs1_o = instr_i[19:15];
	assign rs2_o = instr_i[24:20];

	// --------------------------------------------------
	// Class and source usage
	// --------------------------------------------------
	always_comb begin
		class_o    = rvf_pkg::CLS_OTHER;
		uses_rs1_o = 1'b0;
		uses_rs2_o = 1'b0;
		case (opcode)
			rvf_pkg::LOAD: begin
				class_o    = rvf_pkg::CLS_LOAD;
				uses_rs1_o = 1'b1;
			end
			rvf_pkg::STORE: begin
				class_o    = rvf_pkg::CLS_STORE;
				uses_rs1_o = 1'b1;
				uses_rs2_o = 1'b1;
			end
			rvf_pkg::BRANCH: begin
				class_o    = rvf_pkg::CLS_BRANCH;
				uses_rs1_o = 1'b1;
				uses_rs2_o = 1'b1;
			end
			rvf_pkg::OP, rvf_pkg::OP32: begin
				// M extension shares the opcode and sets funct7 to 1.
				class_o    = (funct7 == 7'h01) ? rvf_pkg::CLS_MULDIV : rvf_pkg::CLS_ALU;
				uses_rs1_o = 1'b1;
				uses_rs2_o = 1'b1;
			end
			rvf_pkg::OP_IMM, rvf_pkg::OP_IMM32: begin
				class_o    = rvf_pkg::CLS_ALU;
				uses_rs1_o = 1'b1;
			end
			rvf_pkg::LUI, rvf_pkg::AUIPC: begin
				class_o = rvf_pkg::CLS_ALU; // Upper immediate, no source register.
			end
			rvf_pkg::JAL: begin
				class_o = rvf_pkg::CLS_JUMP;
			end
			rvf_pkg::JALR: begin
				class_o    = rvf_pkg::CLS_JUMP;
				uses_rs1_o = 1'b1;
			end
			default: begin
				class_o = rvf_pkg::CLS_OTHER;
			end
		endcase
	end

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     redirect_i,
	input  logic [rvf_pkg::XLEN-1:0] redirect_pc_i,
	input  logic                     muldiv_done_i,
	input  logic                     ex_load_valid_i,
	input  logic [4:0]               ex_load_rd_i,
	output logic                     id_valid_o,
	output logic [rvf_pkg::XLEN-1:0] id_pc_o,
	output logic [rvf_pkg::ILEN-1:0] id_instr_o,
	output rvf_pkg::instr_class_e    id_class_o,
	output logic [4:0]               id_rd_o,
	output logic [4:0]               id_rs1_o,
	output logic [4:0]               id_rs2_o,
	output logic                     hold_o
);

	logic [rvf_pkg::XLEN-1:0] if_pc;
	logic [rvf_pkg::ILEN-1:0] if_instr;
	logic                     id_valid;
	logic [rvf_pkg::XLEN-1:0] id_pc;
	logic [rvf_pkg::ILEN-1:0] id_instr;
	rvf_pkg::instr_class_e    id_class;
	logic [4:0]               id_rd;
	logic [4:0]               id_rs1;
	logic [4:0]               id_rs2;
	logic                     id_uses_rs1;
	logic                     id_uses_rs2;
	rvf_pkg::fetch_action_e   action;
	logic                     pc_hold;

	// --------------------------------------------------
	// Fetch stage
	// --------------------------------------------------
	pc_gen u_pc_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.pc_hold_i     (pc_hold),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.pc_o          (if_pc)
	);

	instr_rom u_instr_rom (
		.pc_i    (if_pc),
		.instr_o (if_instr)
	);

	if_id_regs u_if_id_regs (
		.clk           (clk),
		.rst_n         (rst_n),
		.action_i      (action),
		.pc_if_id_i    (if_pc),
		.instr_if_id_i (if_instr),
		.pc_if_id_o    (id_pc),
		.instr_if_id_o (id_instr),
		.valid_if_id_o (id_valid)
	);

	// --------------------------------------------------
	// Decode side and hazard control
	// --------------------------------------------------
	id_classify u_id_classify (
		.instr_i    (id_instr),
		.class_o    (id_class),
		.rd_o       (id_rd),
		.rs1_o      (id_rs1),
		.rs2_o      (id_rs2),
		.uses_rs1_o (id_uses_rs1),
		.uses_rs2_o (id_uses_rs2)
	);

	fetch_hazard_ctrl u_fetch_hazard_ctrl (
		.id_valid_i      (id_valid),
		.id_class_i      (id_class),
		.id_rs1_i        (id_rs1),
		.id_rs2_i        (id_rs2),
		.id_uses_rs1_i   (id_uses_rs1),
		.id_uses_rs2_i   (id_uses_rs2),
		.muldiv_done_i   (muldiv_done_i),
		.ex_load_valid_i (ex_load_valid_i),
		.ex_load_rd_i    (ex_load_rd_i),
		.redirect_i      (redirect_i),
		.action_o        (action),
		.pc_hold_o       (pc_hold)
	);

	assign id_valid_o = id_valid;
	assign id_pc_o    = id_pc;
	assign id_instr_o = id_instr;
	assign id_class_o = id_class;
	assign id_rd_o    = id_rd;
	assign id_rs1_o   = id_rs1;
	assign id_rs2_o   = id_rs2;
	assign hold_o     = (action == rvf_pkg::ACT_HOLD); // Stalls the stages behind ID.

endmodule

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o; // 10 ns period.
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (5) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

/* tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;

	localparam int MAX_CYCLES = 400;

	logic                     clk;
	logic                     rst_n;
	logic                     redirect;
	logic [rvf_pkg::XLEN-1:0] redirect_pc;
	logic                     muldiv_done;
	logic                     ex_load_valid;
	logic [4:0]               ex_load_rd;
	logic                     id_valid;
	logic [rvf_pkg::XLEN-1:0] id_pc;
	logic [rvf_pkg::ILEN-1:0] id_instr;
	rvf_pkg::instr_class_e    id_class;
	logic [4:0]               id_rd;
	logic [4:0]               id_rs1;
	logic [4:0]               id_rs2;
	logic                     hold;

	logic [rvf_pkg::ILEN-1:0] model_rom [16];
	logic [rvf_pkg::XLEN-1:0] model_pc;
	logic                     exp_valid;
	logic [rvf_pkg::XLEN-1:0] exp_pc;
	logic [rvf_pkg::ILEN-1:0] exp_instr;
	logic                     cur_r;
	logic [rvf_pkg::XLEN-1:0] cur_rpc;
	logic                     cur_d;
	logic                     cur_lv;
	logic [4:0]               cur_lrd;
	integer                   seed;
	int                       errors;
	int                       checks;
	int                       test_start;
	int                       cycles;

	tb_clkgen u_clkgen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	fetch_top u_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.redirect_i      (redirect),
		.redirect_pc_i   (redirect_pc),
		.muldiv_done_i   (muldiv_done),
		.ex_load_valid_i (ex_load_valid),
		.ex_load_rd_i    (ex_load_rd),
		.id_valid_o      (id_valid),
		.id_pc_o         (id_pc),
		.id_instr_o      (id_instr),
		.id_class_o      (id_class),
		.id_rd_o         (id_rd),
		.id_rs1_o        (id_rs1),
		.id_rs2_o        (id_rs2),
		.hold_o          (hold)
	);

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic check_pc(input string name, input logic [rvf_pkg::XLEN-1:0] got,
			input logic [rvf_pkg::XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_instr(input string name, input logic [rvf_pkg::ILEN-1:0] got,
			input logic [rvf_pkg::ILEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_class(input string name, input rvf_pkg::instr_class_e got,
			input rvf_pkg::instr_class_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic rvf_pkg::instr_class_e exp_class(input logic [31:0] ins);
		logic [6:0] op;
		op = ins[6:0];
		if (op == rvf_pkg::LOAD) return rvf_pkg::CLS_LOAD;
		if (op == rvf_pkg::STORE) return rvf_pkg::CLS_STORE;
		if (op == rvf_pkg::BRANCH) return rvf_pkg::CLS_BRANCH;
		if (op == rvf_pkg::JAL || op == rvf_pkg::JALR) return rvf_pkg::CLS_JUMP;
		if (op == rvf_pkg::OP || op == rvf_pkg::OP32) begin
			return (ins[31:25] == 7'd1) ? rvf_pkg::CLS_MULDIV : rvf_pkg::CLS_ALU;
		end
		if (op == rvf_pkg::OP_IMM || op == rvf_pkg::OP_IMM32 || op == rvf_pkg::LUI ||
				op == rvf_pkg::AUIPC) return rvf_pkg::CLS_ALU;
		return rvf_pkg::CLS_OTHER;
	endfunction

	function automatic rvf_pkg::fetch_action_e exp_action();
		logic [6:0] op;
		logic       u1;
		logic       u2;
		logic       lu;
		op = exp_instr[6:0];
		u1 = !(op == rvf_pkg::LUI || op == rvf_pkg::AUIPC || op == rvf_pkg::JAL) &&
			exp_class(exp_instr) != rvf_pkg::CLS_OTHER;
		u2 = (op == rvf_pkg::OP || op == rvf_pkg::OP32 || op == rvf_pkg::STORE ||
			op == rvf_pkg::BRANCH);
		lu = cur_lv && cur_lrd != 5'd0 &&
			((u1 && exp_instr[19:15] == cur_lrd) || (u2 && exp_instr[24:20] == cur_lrd));
		if (exp_valid && exp_class(exp_instr) == rvf_pkg::CLS_MULDIV && !cur_d)
			return rvf_pkg::ACT_HOLD;
		if (lu) return rvf_pkg::ACT_HOLD;
		if (cur_r) return rvf_pkg::ACT_FLUSH;
		return rvf_pkg::ACT_ADVANCE;
	endfunction

	task automatic update_model();
		rvf_pkg::fetch_action_e act;
		logic [rvf_pkg::XLEN-1:0] pc_n;
		act = exp_action();
		if (cur_r) pc_n = cur_rpc;
		else if (act == rvf_pkg::ACT_HOLD) pc_n = model_pc;
		else pc_n = model_pc + 64'd4;
		if (act == rvf_pkg::ACT_ADVANCE) begin
			exp_pc    = model_pc;
			exp_instr = model_rom[model_pc[5:2]];
			exp_valid = 1'b1;
		end else if (act == rvf_pkg::ACT_FLUSH) begin
			exp_pc    = model_pc;
			exp_instr = rvf_pkg::NOP_INSTR;
			exp_valid = 1'b0;
		end
		model_pc = pc_n;
	endtask

	task automatic compare_outputs();
		check_bit("id_valid_o", id_valid, exp_valid);
		check_pc("id_pc_o", id_pc, exp_pc);
		check_instr("id_instr_o", id_instr, exp_instr);
		check_class("id_class_o", id_class, exp_class(exp_instr));
		check_reg("id_rd_o", id_rd, exp_instr[11:7]);
		check_reg("id_rs1_o", id_rs1, exp_instr[19:15]);
		check_reg("id_rs2_o", id_rs2, exp_instr[24:20]);
		check_bit("hold_o", hold, exp_action() == rvf_pkg::ACT_HOLD);
	endtask

	// One clock: the model follows the edge, then the next inputs are applied.
	task automatic step(input logic r, input logic [63:0] rpc, input logic d,
			input logic lv, input logic [4:0] lrd);
		@(posedge clk);
		update_model();
		redirect      <= r;
		redirect_pc   <= rpc;
		muldiv_done   <= d;
		ex_load_valid <= lv;
		ex_load_rd    <= lrd;
		cur_r   = r;
		cur_rpc = rpc;
		cur_d   = d;
		cur_lv  = lv;
		cur_lrd = lrd;
		#1;
		compare_outputs();
	endtask

	task automatic idle();
		step(1'b0, 64'd0, 1'b0, 1'b0, 5'd0);
	endtask

	task automatic report_test(input string name);
		if (errors == test_start) $display("[%s] passed", name);
		else $display("[%s] failed with %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic reset_and_sequential();
		compare_outputs();
		check_bit("id_valid_o", id_valid, 1'b0);
		check_instr("id_instr_o", id_instr, rvf_pkg::NOP_INSTR);
		check_pc("id_pc_o", id_pc, rvf_pkg::RESET_PC);
		check_bit("hold_o", hold, 1'b0);
		for (int i = 0; i < 3; i++) begin
			idle();
			check_pc("id_pc_o", id_pc, rvf_pkg::RESET_PC + 64'(4 * i));
		end
		report_test("reset and sequential fetch");
	endtask

	task automatic muldiv_hold();
		int n;
		n = 1 + ({$random(seed)} % 8);
		idle();
		for (int i = 1; i < n; i++) begin
			idle();
			check_pc("id_pc_o", id_pc, rvf_pkg::RESET_PC + 64'd12);
			check_bit("hold_o", hold, 1'b1);
		end
		step(1'b0, 64'd0, 1'b1, 1'b0, 5'd0);
		check_pc("id_pc_o", id_pc, rvf_pkg::RESET_PC + 64'd12);
		idle();
		check_pc("id_pc_o", id_pc, rvf_pkg::RESET_PC + 64'd16); // Nothing skipped.
		report_test("multiply/divide hold");
	endtask

	task automatic load_use_hold();
		step(1'b0, 64'd0, 1'b0, 1'b1, 5'd0); // The addi in ID reads x0.
		check_bit("hold_o", hold, 1'b0);
		step(1'b0, 64'd0, 1'b0, 1'b1, 5'd5);
		check_bit("hold_o", hold, 1'b1);
		step(1'b0, 64'd0, 1'b0, 1'b1, 5'd6);
		check_bit("hold_o", hold, 1'b1);
		step(1'b0, 64'd0, 1'b0, 1'b1, 5'd7);
		check_bit("hold_o", hold, 1'b0);
		step(1'b0, 64'd0, 1'b0, 1'b1, 5'd16); // Store immediate bits, not a source.
		check_bit("hold_o", hold, 1'b0);
		idle();
		step(1'b0, 64'd0, 1'b0, 1'b1, 5'd16); // Offset bits of the jal, not a source.
		check_bit("hold_o", hold, 1'b0);
		check_pc("id_pc_o", id_pc, rvf_pkg::RESET_PC + 64'd36);
		report_test("load-use hold");
	endtask

	task automatic redirect_flush();
		logic [63:0] t;
		t = rvf_pkg::RESET_PC + 64'd12;
		// Neither the target nor the word after it may hold ID.
		while (exp_class(model_rom[t[5:2]]) == rvf_pkg::CLS_MULDIV ||
				exp_class(model_rom[t[5:2] + 4'd1]) == rvf_pkg::CLS_MULDIV) begin
			t = rvf_pkg::RESET_PC + 64'(4 * ({$random(seed)} % 16));
		end
		step(1'b1, t, 1'b0, 1'b0, 5'd0);
		idle();
		check_bit("id_valid_o", id_valid, 1'b0);
		check_instr("id_instr_o", id_instr, rvf_pkg::NOP_INSTR);
		idle();
		check_pc("id_pc_o", id_pc, t);
		report_test("redirect flush");
	endtask

	task automatic redirect_during_hold();
		logic [63:0] t2;
		t2 = rvf_pkg::RESET_PC + 64'd32;
		step(1'b1, rvf_pkg::RESET_PC + 64'd12, 1'b0, 1'b0, 5'd0);
		idle();
		idle();
		check_class("id_class_o", id_class, rvf_pkg::CLS_MULDIV);
		step(1'b1, t2, 1'b0, 1'b0, 5'd0);
		step(1'b0, 64'd0, 1'b1, 1'b0, 5'd0);
		check_pc("id_pc_o", id_pc, rvf_pkg::RESET_PC + 64'd12); // MUL kept.
		idle();
		check_pc("id_pc_o", id_pc, t2);
		report_test("redirect during hold");
	endtask

	task automatic field_decode();
		step(1'b1, rvf_pkg::RESET_PC, 1'b1, 1'b0, 5'd0);
		step(1'b0, 64'd0, 1'b1, 1'b0, 5'd0);
		for (int i = 0; i < 16; i++) begin
			step(1'b0, 64'd0, 1'b1, 1'b0, 5'd0);
			check_pc("id_pc_o", id_pc, rvf_pkg::RESET_PC + 64'(4 * i));
		end
		idle();
		report_test("field decode");
	endtask

	// --------------------------------------------------
	// Run control
	// --------------------------------------------------
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		redirect      = 1'b0;
		redirect_pc   = '0;
		muldiv_done   = 1'b0;
		ex_load_valid = 1'b0;
		ex_load_rd    = 5'd0;
		cur_r   = 1'b0;
		cur_rpc = '0;
		cur_d   = 1'b0;
		cur_lv  = 1'b0;
		cur_lrd = 5'd0;
		seed       = 32'h81ff_cc0c;
		errors     = 0;
		checks     = 0;
		test_start = 0;
		cycles     = 0;
		model_pc   = rvf_pkg::RESET_PC;
		exp_valid  = 1'b0;
		exp_pc     = rvf_pkg::RESET_PC;
		exp_instr  = rvf_pkg::NOP_INSTR;
		$readmemh("program.hex", model_rom);
		@(posedge rst_n);
		#1;
		reset_and_sequential();
		muldiv_hold();
		load_use_hold();
		redirect_flush();
		redirect_during_hold();
		field_decode();
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* program.hex */
// One 32-bit RV64 instruction per line, word 0 at the reset vector.
00500093
0000B103
00700193
02308233
00812283
00100313
006283B3
00713823
00308463
010000EF
12345437
00001497
00008067
0030851B
0230C5BB
40638633

/* sources.f */
rvf_pkg.sv
pc_gen.sv
instr_rom.sv
if_id_regs.sv
fetch_hazard_ctrl.sv
id_classify.sv
fetch_top.sv
tb_clkgen.sv
tb_fetch_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FLIST     ?= sources.f
VFLAGS    ?= --binary --timing -Wall

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN) program.hex
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
